// ==== dcache_bus_master.sv ====
/*
  line burst master for the memory bus
  a command seen in idle is latched with its line address and line;
  bus_req_o is held until grant, then four acknowledged beats follow,
  word 0 first. done_o pulses on the last beat, with the read line
*/
module dcache_bus_master (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  dcache_pkg::bus_cmd_e           cmd_i,
  input  logic [dcache_pkg::ADDR_W-1:0]  line_addr_i,
  input  logic [dcache_pkg::LINE_W-1:0]  wb_line_i,
  input  logic                           bus_gnt_i,
  input  logic                           bus_ack_i,
  input  logic [dcache_pkg::XLEN-1:0]    bus_rdata_i,
  output logic                           bus_req_o,
  output logic                           bus_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]  bus_addr_o,
  output logic [dcache_pkg::XLEN-1:0]    bus_wdata_o,
  output logic                           done_o,
  output logic [dcache_pkg::LINE_W-1:0]  fill_line_o
);

  dcache_pkg::bus_state_e              state_q;
  dcache_pkg::bus_cmd_e                cmd_q;
  logic [dcache_pkg::ADDR_W-1:0]       addr_q;
  logic [dcache_pkg::LINE_W-1:0]       line_q;  // shifts one word per beat
  logic [dcache_pkg::WORD_OFF_W-1:0]   beat_q;
  logic                                last_beat;

  assign last_beat = (state_q == dcache_pkg::BUS_BURST) & bus_ack_i & (&beat_q);

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dcache_pkg::BUS_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        dcache_pkg::BUS_IDLE:
          if (cmd_i != dcache_pkg::CMD_NONE) begin
            state_q <= dcache_pkg::BUS_WAIT_GNT;
            beat_q  <= '0;
          end
        dcache_pkg::BUS_WAIT_GNT:
          if (bus_gnt_i) state_q <= dcache_pkg::BUS_BURST;
        default: begin
          if (bus_ack_i) beat_q <= beat_q + 1'b1;  // wraps to 0 after word 3
          if (last_beat) state_q <= dcache_pkg::BUS_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // payload
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == dcache_pkg::BUS_IDLE && cmd_i != dcache_pkg::CMD_NONE) begin
      cmd_q  <= cmd_i;
      addr_q <= line_addr_i;
      line_q <= wb_line_i;
    end else if (state_q == dcache_pkg::BUS_BURST && bus_ack_i) begin
      // write: next word moves down; read: returned word enters at the top
      line_q <= {bus_rdata_i, line_q[dcache_pkg::LINE_W-1:dcache_pkg::XLEN]};
    end
  end

  assign bus_req_o   = (state_q == dcache_pkg::BUS_WAIT_GNT);
  assign bus_we_o    = (cmd_q == dcache_pkg::CMD_WRITE_LINE);
  assign bus_addr_o  = addr_q;                              // line base
  assign bus_wdata_o = line_q[dcache_pkg::XLEN-1:0];
  assign done_o      = last_beat;
  // last word still on the bus in the done cycle
  assign fill_line_o = {bus_rdata_i, line_q[dcache_pkg::LINE_W-1:dcache_pkg::XLEN]};

endmodule

// ==== dcache_ctrl.sv ====
/*
  cache controller: lookup / write-back / fill / replay FSM
  hits respond in the lookup cycle, a write hit stalls the next accept
  a miss freezes the LFSR victim, writes it back only when valid and dirty,
  fills the line clean, then replays the request through lookup
*/
module dcache_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               lk_valid_i,
  input  logic                               lk_we_i,
  input  logic [dcache_pkg::IDX_W-1:0]       lk_idx_i,
  input  logic [dcache_pkg::TAG_W-1:0]       lk_tag_i,
  input  logic [dcache_pkg::IDX_W-1:0]       rd_idx_i,
  input  logic [dcache_pkg::WAYS-1:0]        hit_i,
  input  logic                               victim_valid_i,
  input  logic                               victim_dirty_i,
  input  logic [dcache_pkg::TAG_W-1:0]       victim_tag_i,
  input  logic [dcache_pkg::LINE_W-1:0]      victim_line_i,
  input  logic [dcache_pkg::XLEN-1:0]        hit_word_i,
  input  logic                               bus_done_i,
  input  logic [dcache_pkg::LINE_W-1:0]      fill_line_i,
  output logic                               accept_o,
  output logic [dcache_pkg::IDX_W-1:0]       arr_rd_idx_o,
  output logic [dcache_pkg::WAYS-1:0]        tag_we_o,
  output logic [dcache_pkg::WAYS-1:0]        dirty_we_o,
  output logic                               dirty_val_o,
  output logic [dcache_pkg::WAYS-1:0]        word_we_o,
  output logic [dcache_pkg::WAYS-1:0]        line_we_o,
  output logic [dcache_pkg::LINE_W-1:0]      line_data_o,
  output logic [dcache_pkg::WAY_IDX_W-1:0]   victim_way_o,
  output dcache_pkg::bus_cmd_e               bus_cmd_o,
  output logic [dcache_pkg::ADDR_W-1:0]      bus_line_addr_o,
  output logic [dcache_pkg::LINE_W-1:0]      wb_line_o,
  output logic                               cpu_ready_o,
  output logic                               cpu_rsp_valid_o,
  output logic [dcache_pkg::XLEN-1:0]        cpu_rdata_o
);

  localparam int LINE_OFF_W = dcache_pkg::WORD_OFF_W + dcache_pkg::BYTE_OFF_W;

  dcache_pkg::ctrl_state_e        state_q, state_d;
  logic                           replay_q;  // refetched request waits in lookup
  logic [dcache_pkg::LFSR_W-1:0]  lfsr_q;
  logic [dcache_pkg::WAYS-1:0]    victim_oh;
  logic                           lookup, pending, hit, miss;

  assign lookup  = (state_q == dcache_pkg::CTRL_LOOKUP);
  assign pending = lk_valid_i | replay_q;
  assign hit     = |hit_i;
  assign miss    = lookup & pending & ~hit;

  // ----------------------------------------------------------
  // cpu side
  // ----------------------------------------------------------
  assign cpu_ready_o     = lookup & ~(pending & (lk_we_i | ~hit));  // writes and misses stall
  assign accept_o        = cpu_ready_o;
  assign cpu_rsp_valid_o = lookup & pending & hit;
  assign cpu_rdata_o     = hit_word_i;
  // hold the pending index whenever nothing new is taken
  assign arr_rd_idx_o    = cpu_ready_o ? rd_idx_i : lk_idx_i;

  // ----------------------------------------------------------
  // array writes
  // ----------------------------------------------------------
  assign victim_way_o = lfsr_q[dcache_pkg::WAY_IDX_W-1:0];  // frozen outside lookup
  assign victim_oh    = {{(dcache_pkg::WAYS-1){1'b0}}, 1'b1} << victim_way_o;
  assign word_we_o    = (lookup & pending & lk_we_i) ? hit_i : '0;
  assign line_we_o    = (state_q == dcache_pkg::CTRL_FILL && bus_done_i) ? victim_oh : '0;
  assign tag_we_o     = line_we_o;  // install tag with the line
  assign dirty_we_o   = word_we_o | line_we_o;
  assign dirty_val_o  = lookup;     // fill lands clean
  assign line_data_o  = fill_line_i;

  // ----------------------------------------------------------
  // bus commands, held level until the burst finishes
  // ----------------------------------------------------------
  always_comb begin
    case (state_q)
      dcache_pkg::CTRL_WB:   bus_cmd_o = dcache_pkg::CMD_WRITE_LINE;
      dcache_pkg::CTRL_FILL: bus_cmd_o = dcache_pkg::CMD_READ_LINE;
      default:               bus_cmd_o = dcache_pkg::CMD_NONE;
    endcase
  end

  assign bus_line_addr_o = {(state_q == dcache_pkg::CTRL_WB) ? victim_tag_i : lk_tag_i,
                            lk_idx_i, {LINE_OFF_W{1'b0}}};
  assign wb_line_o       = victim_line_i;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::CTRL_LOOKUP:
        if (miss) state_d = (victim_valid_i & victim_dirty_i) ? dcache_pkg::CTRL_WB
                                                              : dcache_pkg::CTRL_FILL;
      dcache_pkg::CTRL_WB:   if (bus_done_i) state_d = dcache_pkg::CTRL_FILL;
      dcache_pkg::CTRL_FILL: if (bus_done_i) state_d = dcache_pkg::CTRL_REPLAY;
      default:               state_d = dcache_pkg::CTRL_LOOKUP;  // replay re-read done
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= dcache_pkg::CTRL_LOOKUP;
      replay_q <= 1'b0;
      lfsr_q   <= 16'h0001;
    end else begin
      state_q  <= state_d;
      replay_q <= (state_q == dcache_pkg::CTRL_REPLAY);
      if (lookup && !miss)  // x^16 + x^15 + x^13 + x^4 + 1
        lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3]};
    end
  end

endmodule

// ==== dcache_data_array.sv ====
/*
  line store of the data cache, one line RAM per way
  write hits update one word under byte enables, fills write a whole line
  read is synchronous; the hit way's word goes to the cpu and the
  victim's whole line goes to the bus master for write-back
*/
module dcache_data_array (
  input  logic                                clk_i,
  input  logic [dcache_pkg::IDX_W-1:0]        rd_idx_i,
  input  logic [dcache_pkg::IDX_W-1:0]        wr_idx_i,
  input  logic [dcache_pkg::WAYS-1:0]         word_we_i,
  input  logic [dcache_pkg::WORD_OFF_W-1:0]   word_sel_i,
  input  logic [dcache_pkg::BE_W-1:0]         word_be_i,
  input  logic [dcache_pkg::XLEN-1:0]         word_data_i,
  input  logic [dcache_pkg::WAYS-1:0]         line_we_i,
  input  logic [dcache_pkg::LINE_W-1:0]       line_data_i,
  input  logic [dcache_pkg::WAYS-1:0]         hit_i,
  input  logic [dcache_pkg::WAY_IDX_W-1:0]    victim_way_i,
  output logic [dcache_pkg::XLEN-1:0]         hit_word_o,
  output logic [dcache_pkg::LINE_W-1:0]       victim_line_o
);

  logic [dcache_pkg::LINE_W-1:0]    line_mem [dcache_pkg::WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::LINE_W-1:0]    line_rd  [dcache_pkg::WAYS];
  logic [dcache_pkg::WAY_IDX_W-1:0] hit_way;

  // ----------------------------------------------------------
  // write port, fill wins over word write
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < dcache_pkg::WAYS; w++) begin
      if (line_we_i[w]) begin
        line_mem[w][wr_idx_i] <= line_data_i;
      end else if (word_we_i[w]) begin
        for (int b = 0; b < dcache_pkg::BE_W; b++) begin
          if (word_be_i[b])
            line_mem[w][wr_idx_i][word_sel_i*dcache_pkg::XLEN + b*8 +: 8] <= word_data_i[b*8 +: 8];
        end
      end
      line_rd[w] <= line_mem[w][rd_idx_i];  // old data on same-edge write
    end
  end

  // one-hot hit to way number
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < dcache_pkg::WAYS; w++) begin
      if (hit_i[w]) hit_way = w[dcache_pkg::WAY_IDX_W-1:0];
    end
  end

  assign hit_word_o    = line_rd[hit_way][word_sel_i*dcache_pkg::XLEN +: dcache_pkg::XLEN];
  assign victim_line_o = line_rd[victim_way_i];

endmodule

// ==== dcache_pkg.sv ====
/*
  shared definitions for the two-way write-back data cache
  geometry, address field widths and the FSM / bus command enums
  every cache module refers to these through dcache_pkg:: names
*/
package dcache_pkg;

  // ----------------------------------------------------------
  // geometry
  // ----------------------------------------------------------
  localparam int XLEN           = 32;  // data word
  localparam int ADDR_W         = 32;  // byte address
  localparam int BE_W           = XLEN / 8;
  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = XLEN * WORDS_PER_LINE;  // 16 byte line

  // address split: tag | index | word | byte
  localparam int BYTE_OFF_W = 2;
  localparam int WORD_OFF_W = 2;
  localparam int IDX_W      = 4;
  localparam int TAG_W      = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W;
  localparam int WAY_IDX_W  = 1;
  localparam int LFSR_W     = 16;  // replacement random source

  // ----------------------------------------------------------
  // FSM encodings
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    CTRL_LOOKUP,  // tag compare, hit response
    CTRL_WB,      // dirty victim going out
    CTRL_FILL,    // new line coming in
    CTRL_REPLAY   // re-read arrays after fill
  } ctrl_state_e;

  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_READ_LINE,
    CMD_WRITE_LINE
  } bus_cmd_e;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_WAIT_GNT,
    BUS_BURST
  } bus_state_e;

endpackage

// ==== dcache_req_stage.sv ====
/*
  cpu request register of the data cache
  a request is taken when cpu_req_i meets accept_i (the cache ready)
  and is held as index / tag / word fields for the lookup cycle
  rd_idx_o starts the array read in the acceptance cycle itself
*/
module dcache_req_stage (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cpu_req_i,
  input  logic                            cpu_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]   cpu_addr_i,
  input  logic [dcache_pkg::XLEN-1:0]     cpu_wdata_i,
  input  logic [dcache_pkg::BE_W-1:0]     cpu_be_i,
  input  logic                            accept_i,
  output logic                            lk_valid_o,
  output logic                            lk_we_o,
  output logic [dcache_pkg::IDX_W-1:0]    lk_idx_o,
  output logic [dcache_pkg::TAG_W-1:0]    lk_tag_o,
  output logic [dcache_pkg::WORD_OFF_W-1:0] lk_word_o,
  output logic [dcache_pkg::XLEN-1:0]     lk_wdata_o,
  output logic [dcache_pkg::BE_W-1:0]     lk_be_o,
  output logic [dcache_pkg::IDX_W-1:0]    rd_idx_o
);

  localparam int IDX_LSB = dcache_pkg::BYTE_OFF_W + dcache_pkg::WORD_OFF_W;

  logic accept;

  assign accept   = cpu_req_i & accept_i;
  assign rd_idx_o = cpu_addr_i[IDX_LSB +: dcache_pkg::IDX_W];  // same-cycle array read

  // valid drops whenever nothing is taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) lk_valid_o <= 1'b0;
    else         lk_valid_o <= accept;
  end

  // request fields, held through a miss
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lk_we_o    <= cpu_we_i;
      lk_idx_o   <= cpu_addr_i[IDX_LSB +: dcache_pkg::IDX_W];
      lk_tag_o   <= cpu_addr_i[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
      lk_word_o  <= cpu_addr_i[dcache_pkg::BYTE_OFF_W +: dcache_pkg::WORD_OFF_W];
      lk_wdata_o <= cpu_wdata_i;
      lk_be_o    <= cpu_be_i;
    end
  end

endmodule

// ==== dcache_tag_array.sv ====
/*
  tag store of the data cache, one tag RAM per way
  valid and dirty bits live in flip-flops and clear on reset
  the tag read is synchronous, compare against cmp_tag_i gives hit_o
  the victim way's valid / dirty / tag feed the miss decision
*/
module dcache_tag_array (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [dcache_pkg::IDX_W-1:0]       rd_idx_i,
  input  logic [dcache_pkg::TAG_W-1:0]       cmp_tag_i,
  input  logic [dcache_pkg::IDX_W-1:0]       wr_idx_i,
  input  logic [dcache_pkg::WAYS-1:0]        tag_we_i,
  input  logic [dcache_pkg::TAG_W-1:0]       wr_tag_i,
  input  logic [dcache_pkg::WAYS-1:0]        dirty_we_i,
  input  logic                               dirty_val_i,
  input  logic [dcache_pkg::WAY_IDX_W-1:0]   victim_way_i,
  output logic [dcache_pkg::WAYS-1:0]        hit_o,
  output logic                               victim_valid_o,
  output logic                               victim_dirty_o,
  output logic [dcache_pkg::TAG_W-1:0]       victim_tag_o
);

  logic [dcache_pkg::TAG_W-1:0] tag_mem [dcache_pkg::WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::TAG_W-1:0] tag_rd  [dcache_pkg::WAYS];
  logic [dcache_pkg::SETS-1:0]  valid_q [dcache_pkg::WAYS];
  logic [dcache_pkg::SETS-1:0]  dirty_q [dcache_pkg::WAYS];
  logic [dcache_pkg::IDX_W-1:0] rd_idx_q;  // index of the registered read

  // ----------------------------------------------------------
  // tag RAM, sync read
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    rd_idx_q <= rd_idx_i;
    for (int w = 0; w < dcache_pkg::WAYS; w++) begin
      if (tag_we_i[w]) tag_mem[w][wr_idx_i] <= wr_tag_i;
      tag_rd[w] <= tag_mem[w][rd_idx_i];
    end
  end

  // status bits, a fill sets valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < dcache_pkg::WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else begin
      for (int w = 0; w < dcache_pkg::WAYS; w++) begin
        if (tag_we_i[w])   valid_q[w][wr_idx_i] <= 1'b1;
        if (dirty_we_i[w]) dirty_q[w][wr_idx_i] <= dirty_val_i;  // set on write, clear on fill
      end
    end
  end

  // ----------------------------------------------------------
  // compare and victim report
  // ----------------------------------------------------------
  always_comb begin
    for (int w = 0; w < dcache_pkg::WAYS; w++) begin
      hit_o[w] = valid_q[w][rd_idx_q] & (tag_rd[w] == cmp_tag_i);
    end
  end

  assign victim_valid_o = valid_q[victim_way_i][rd_idx_q];
  assign victim_dirty_o = dirty_q[victim_way_i][rd_idx_q];
  assign victim_tag_o   = tag_rd[victim_way_i];  // forms the write-back address

endmodule

// ==== dcache_top.f ====
dcache_pkg.sv
dcache_req_stage.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache_bus_master.sv
dcache_top.sv
dcache_top_assertions.sv
tb_dcache_top.sv

// ==== dcache_top.sv ====
/*
  two-way write-back, write-allocate data cache
  cpu ready/valid request port in front, line burst bus master behind
  request stage feeds the controller and arrays, misses go out through
  the bus master as write-back and fill bursts
*/
module dcache_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           cpu_req_i,
  input  logic                           cpu_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]  cpu_addr_i,
  input  logic [dcache_pkg::XLEN-1:0]    cpu_wdata_i,
  input  logic [dcache_pkg::BE_W-1:0]    cpu_be_i,
  output logic                           cpu_ready_o,
  output logic                           cpu_rsp_valid_o,
  output logic [dcache_pkg::XLEN-1:0]    cpu_rdata_o,
  output logic                           bus_req_o,
  output logic                           bus_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]  bus_addr_o,
  output logic [dcache_pkg::XLEN-1:0]    bus_wdata_o,
  input  logic                           bus_gnt_i,
  input  logic                           bus_ack_i,
  input  logic [dcache_pkg::XLEN-1:0]    bus_rdata_i
);

  // request stage
  logic                                lk_valid, lk_we, accept;
  logic [dcache_pkg::IDX_W-1:0]        lk_idx, rd_idx, arr_rd_idx;
  logic [dcache_pkg::TAG_W-1:0]        lk_tag, victim_tag;
  logic [dcache_pkg::WORD_OFF_W-1:0]   lk_word;
  logic [dcache_pkg::XLEN-1:0]         lk_wdata, hit_word;
  logic [dcache_pkg::BE_W-1:0]         lk_be;
  // arrays
  logic [dcache_pkg::WAYS-1:0]         hit, tag_we, dirty_we, word_we, line_we;
  logic                                victim_valid, victim_dirty, dirty_val;
  logic [dcache_pkg::WAY_IDX_W-1:0]    victim_way;
  logic [dcache_pkg::LINE_W-1:0]       victim_line, line_data, wb_line, fill_line;
  // bus master
  dcache_pkg::bus_cmd_e                bus_cmd;
  logic [dcache_pkg::ADDR_W-1:0]       bus_line_addr;
  logic                                bus_done;

  dcache_req_stage i_req_stage (
    .clk_i, .rst_ni, .cpu_req_i, .cpu_we_i, .cpu_addr_i, .cpu_wdata_i, .cpu_be_i,
    .accept_i  (accept),
    .lk_valid_o(lk_valid), .lk_we_o(lk_we), .lk_idx_o(lk_idx), .lk_tag_o(lk_tag),
    .lk_word_o (lk_word), .lk_wdata_o(lk_wdata), .lk_be_o(lk_be), .rd_idx_o(rd_idx)
  );

  dcache_tag_array i_tag_array (
    .clk_i, .rst_ni,
    .rd_idx_i  (arr_rd_idx), .cmp_tag_i(lk_tag), .wr_idx_i(lk_idx),
    .tag_we_i  (tag_we), .wr_tag_i(lk_tag), .dirty_we_i(dirty_we), .dirty_val_i(dirty_val),
    .victim_way_i(victim_way), .hit_o(hit), .victim_valid_o(victim_valid),
    .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
  );

  dcache_data_array i_data_array (
    .clk_i,
    .rd_idx_i  (arr_rd_idx), .wr_idx_i(lk_idx), .word_we_i(word_we), .word_sel_i(lk_word),
    .word_be_i (lk_be), .word_data_i(lk_wdata), .line_we_i(line_we), .line_data_i(line_data),
    .hit_i     (hit), .victim_way_i(victim_way),
    .hit_word_o(hit_word), .victim_line_o(victim_line)
  );

  dcache_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .lk_valid_i(lk_valid), .lk_we_i(lk_we), .lk_idx_i(lk_idx), .lk_tag_i(lk_tag),
    .rd_idx_i  (rd_idx), .hit_i(hit), .victim_valid_i(victim_valid),
    .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag), .victim_line_i(victim_line),
    .hit_word_i(hit_word), .bus_done_i(bus_done), .fill_line_i(fill_line),
    .accept_o  (accept), .arr_rd_idx_o(arr_rd_idx), .tag_we_o(tag_we),
    .dirty_we_o(dirty_we), .dirty_val_o(dirty_val), .word_we_o(word_we),
    .line_we_o (line_we), .line_data_o(line_data), .victim_way_o(victim_way),
    .bus_cmd_o (bus_cmd), .bus_line_addr_o(bus_line_addr), .wb_line_o(wb_line),
    .cpu_ready_o, .cpu_rsp_valid_o, .cpu_rdata_o
  );

  dcache_bus_master i_bus_master (
    .clk_i, .rst_ni,
    .cmd_i     (bus_cmd), .line_addr_i(bus_line_addr), .wb_line_i(wb_line),
    .bus_gnt_i, .bus_ack_i, .bus_rdata_i,
    .bus_req_o, .bus_we_o, .bus_addr_o, .bus_wdata_o,
    .done_o    (bus_done), .fill_line_o(fill_line)
  );

endmodule

// ==== dcache_top_assertions.sv ====
/*
  handshake checks on the cpu and memory bus ports of the data cache
  bound into dcache_top by the testbench, which reads fail_count at the end
*/
module dcache_top_assertions (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          cpu_ready_o,
  input logic                          cpu_rsp_valid_o,
  input logic                          bus_req_o,
  input logic                          bus_we_o,
  input logic [dcache_pkg::ADDR_W-1:0] bus_addr_o,
  input logic                          bus_gnt_i
);

  int fail_count = 0;  // failed assertion count

  // ----------------------------------------------------------
  // memory bus request phase
  // ----------------------------------------------------------
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_addr_o) && $stable(bus_we_o))
    else begin
      $error("bus request, address or direction changed before grant");
      fail_count++;
    end

  req_drop_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && bus_gnt_i |=> !bus_req_o)  // one grant per burst
    else begin
      $error("bus request still high after grant");
      fail_count++;
    end

  // ----------------------------------------------------------
  // cpu response
  // ----------------------------------------------------------
  // stalled response is a single pulse
  rsp_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_rsp_valid_o && !cpu_ready_o |=> !cpu_rsp_valid_o)
    else begin
      $error("response valid twice in a row after a stalled cycle");
      fail_count++;
    end

  reset_idle_a : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !bus_req_o)
    else begin
      $error("bus request high when leaving reset");
      fail_count++;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_dcache_top -f dcache_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dcache_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0

// ==== tb_dcache_top.sv ====
/*
  testbench for the two-way write-back data cache
  random cpu reads and byte-enabled writes over three tags sharing index
  sets, a memory responder with random grant / ack delays and a flat
  word model; read data and write-back beats are checked against it
*/
module tb_dcache_top;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_REQ    = 2000;
  localparam int TIMEOUT    = NUM_REQ * 40 * CLK_PERIOD;  // 40 cycles per request
  localparam int MEM_WORDS  = 256;  // word address bits [9:2], tags 1..3

  logic                            clk_i;
  logic                            rst_ni;
  logic                            cpu_req_i;
  logic                            cpu_we_i;
  logic [dcache_pkg::ADDR_W-1:0]   cpu_addr_i;
  logic [dcache_pkg::XLEN-1:0]     cpu_wdata_i;
  logic [dcache_pkg::BE_W-1:0]     cpu_be_i;
  logic                            cpu_ready_o;
  logic                            cpu_rsp_valid_o;
  logic [dcache_pkg::XLEN-1:0]     cpu_rdata_o;
  logic                            bus_req_o;
  logic                            bus_we_o;
  logic [dcache_pkg::ADDR_W-1:0]   bus_addr_o;
  logic [dcache_pkg::XLEN-1:0]     bus_wdata_o;
  logic                            bus_gnt_i;
  logic                            bus_ack_i;
  logic [dcache_pkg::XLEN-1:0]     bus_rdata_i;

  logic [31:0] model_mem   [MEM_WORDS];  // golden view, updated at acceptance
  logic [31:0] backing_mem [MEM_WORDS];  // what the memory really holds
  bit          exp_we_q   [$];           // expected responses, acceptance order
  logic [31:0] exp_data_q [$];
  logic [31:0] exp_addr_q [$];

  integer      seed;
  int          errors;
  int          checks;
  int          issued;
  bit          accepted;    // last driven request taken at the edge
  int          mem_phase;   // 0 idle, 1 grant delay, 2 burst beats
  int          mem_delay;
  int          mem_beat;
  logic [31:0] burst_addr;
  logic        burst_we;

  dcache_top i_dcache_top (
    .clk_i, .rst_ni, .cpu_req_i, .cpu_we_i, .cpu_addr_i, .cpu_wdata_i, .cpu_be_i,
    .cpu_ready_o, .cpu_rsp_valid_o, .cpu_rdata_o,
    .bus_req_o, .bus_we_o, .bus_addr_o, .bus_wdata_o, .bus_gnt_i, .bus_ack_i, .bus_rdata_i
  );

  bind dcache_top dcache_top_assertions i_top_assertions (
    .clk_i, .rst_ni, .cpu_ready_o, .cpu_rsp_valid_o,
    .bus_req_o, .bus_we_o, .bus_addr_o, .bus_gnt_i
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];  // enabled lanes only
    end
    return merged;
  endfunction

  // 16 lines over tags 1..3, three lines per set in sets 0..4, one in set 5
  function automatic logic [31:0] word_to_addr(input logic [5:0] w);
    logic [3:0]  line;
    logic [23:0] tag;
    logic [3:0]  idx;
    line = w[5:2];
    tag  = 24'(line % 3) + 24'd1;
    idx  = 4'(line / 3);
    return {tag, idx, w[1:0], 2'b00};
  endfunction

  task automatic record_accept();
    logic [7:0] wa;
    wa = cpu_addr_i[9:2];
    if (cpu_we_i) begin
      model_mem[wa] = merge_bytes(model_mem[wa], cpu_wdata_i, cpu_be_i);
      exp_data_q.push_back(32'h0);
    end else begin
      exp_data_q.push_back(model_mem[wa]);  // sees every earlier write
    end
    exp_we_q.push_back(cpu_we_i);
    exp_addr_q.push_back(cpu_addr_i);
    issued++;
  endtask

  // ----------------------------------------------------------
  // per falling edge: response check, memory, cpu drive
  // ----------------------------------------------------------
  task automatic check_response();
    logic        we;
    logic [31:0] data;
    logic [31:0] addr;
    if (cpu_rsp_valid_o) begin
      if (exp_we_q.size() == 0) begin
        errors++;
        $display("error at %0t: response without an accepted request", $time);
      end else begin
        we   = exp_we_q.pop_front();
        data = exp_data_q.pop_front();
        addr = exp_addr_q.pop_front();
        if (!we) begin
          check_value($sformatf("cpu_rdata_o[0x%08h]", addr), cpu_rdata_o, data);
          check_value("cpu_ready_o", {31'b0, cpu_ready_o}, 32'h1);  // read never stalls
        end
      end
    end
  endtask

  task automatic serve_memory();
    logic [31:0] rnd;
    logic [7:0]  wa;
    logic [31:0] miss_addr;
    bus_gnt_i = 1'b0;
    bus_ack_i = 1'b0;
    if (mem_phase == 0 && bus_req_o) begin
      burst_addr = bus_addr_o;
      burst_we   = bus_we_o;
      mem_beat   = 0;
      rnd        = $random(seed);
      mem_delay  = int'(rnd[1:0]);
      mem_phase  = 1;
      check_value("bus_addr_o[3:0]", {28'h0, bus_addr_o[3:0]}, 32'h0);  // line base
      if (bus_addr_o[31:10] != '0) begin
        errors++;
        $display("error at %0t: bus address 0x%08h outside the test range", $time, bus_addr_o);
      end
      if (exp_addr_q.size() != 0) begin
        // the fill is for the missing line, a write-back for another line
        miss_addr = exp_addr_q[exp_addr_q.size()-1];
        check_value("bus_we_o", {31'b0, bus_we_o},
                    {31'b0, bus_addr_o[31:4] != miss_addr[31:4]});
      end
    end
    if (mem_phase == 1) begin
      if (!bus_req_o) begin
        errors++;
        $display("error at %0t: bus request dropped before grant", $time);
      end
      if (mem_delay == 0) begin
        bus_gnt_i = 1'b1;
        rnd       = $random(seed);
        mem_delay = int'(rnd[1:0]);
        mem_phase = 2;
      end else mem_delay--;
    end else if (mem_phase == 2) begin
      if (bus_req_o) begin
        errors++;
        $display("error at %0t: new bus request inside a burst", $time);
      end
      if (mem_delay == 0) begin
        wa        = {burst_addr[9:4], 2'(mem_beat)};  // words 0..3 in order
        bus_ack_i = 1'b1;
        if (burst_we) begin
          check_value($sformatf("bus_wdata_o[0x%08h]", {burst_addr[31:4], 2'(mem_beat), 2'b00}),
                      bus_wdata_o, model_mem[wa]);
          backing_mem[wa] = bus_wdata_o;
        end else begin
          bus_rdata_i = backing_mem[wa];
        end
        mem_beat++;
        rnd       = $random(seed);
        mem_delay = int'(rnd[1:0]);
        if (mem_beat == 4) mem_phase = 0;  // exactly four beats
      end else mem_delay--;
    end
  endtask

  task automatic drive_cpu();
    logic [31:0] rnd;
    if (!cpu_req_i || accepted) begin  // a held request stays until taken
      rnd = $random(seed);
      if (issued >= NUM_REQ || rnd[1:0] == 2'd0) begin
        cpu_req_i = 1'b0;
      end else begin
        cpu_req_i   = 1'b1;
        cpu_we_i    = (rnd[4:2] < 3'd3);  // about 3 in 8 writes
        cpu_be_i    = rnd[11:8];
        cpu_addr_i  = word_to_addr(rnd[21:16]);
        cpu_wdata_i = $random(seed);
      end
    end
    // ready only moves at rising edges, so this is the acceptance
    accepted = cpu_req_i && cpu_ready_o;
    if (accepted) record_accept();
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin : stimulus
    seed        = 4;
    errors      = 0;
    checks      = 0;
    issued      = 0;
    accepted    = 1'b0;
    mem_phase   = 0;
    mem_delay   = 0;
    mem_beat    = 0;
    cpu_req_i   = 1'b0;
    cpu_we_i    = 1'b0;
    cpu_addr_i  = '0;
    cpu_wdata_i = '0;
    cpu_be_i    = '0;
    bus_gnt_i   = 1'b0;
    bus_ack_i   = 1'b0;
    bus_rdata_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i]   = 32'(i);  // word address as data
      backing_mem[i] = 32'(i);
    end
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("cpu_ready_o", {31'b0, cpu_ready_o}, 32'h1);
    check_value("cpu_rsp_valid_o", {31'b0, cpu_rsp_valid_o}, 32'h0);
    check_value("bus_req_o", {31'b0, bus_req_o}, 32'h0);

    while (issued < NUM_REQ || exp_we_q.size() != 0) begin
      @(negedge clk_i);
      check_response();
      serve_memory();
      drive_cpu();
    end
    cpu_req_i = 1'b0;
    // quiet tail, nothing more may come back
    repeat (20) begin
      @(negedge clk_i);
      check_response();
      serve_memory();
    end
    if (exp_we_q.size() != 0) begin
      errors++;
      $display("error: %0d accepted requests never got a response", exp_we_q.size());
    end
    errors += i_dcache_top.i_top_assertions.fail_count;  // handshake assertions

    $display("done: %0d requests, %0d checks, %0d errors", issued, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("watchdog: run did not finish within %0d time units", TIMEOUT);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
